//--- src/fc_pkg.sv
// FC layer shared definitions
`default_nettype none

package fc_pkg;

    //////////////////////////////
    // Layer dimensions
    //////////////////////////////

    // One int8 data byte
    localparam int BYTE_W    = 8;
    // Stream word width
    localparam int WORD_W    = 32;
    // Input features, also MAC steps per output
    localparam int IN_COUNT  = 8;
    // Outputs, one lane each
    localparam int OUT_COUNT = 4;
    // Unquantized accumulator width
    localparam int ACC_W     = 20;

    // Packed feature vector, also one lane's weight row
    localparam int FEATURE_W = IN_COUNT * BYTE_W;

    // Features + weight matrix + biases, in stream words
    localparam int FRAME_WORDS = (FEATURE_W + OUT_COUNT * FEATURE_W
                                  + OUT_COUNT * BYTE_W) / WORD_W;

    // Lane MAC step counter
    localparam int STEP_W = 4;

    //////////////////////////////
    // FSM encodings
    //////////////////////////////

    typedef enum logic {
        LOAD_RECEIVE,
        LOAD_COMPUTE
    } loader_state_t;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_ACCUMULATE,
        LANE_BIAS_ADD,
        LANE_DONE
    } lane_state_t;

endpackage

`default_nettype wire

//--- src/fc_frame_loader.sv
// FC frame loader
`timescale 1ns/1ns
`default_nettype none

module fc_frame_loader
    import fc_pkg::*;
(
    input  wire logic                                clk,
    input  wire logic                                rstn,
    input  wire logic                                in_valid,
    input  wire logic [WORD_W-1:0]                   in_data,
    input  wire logic                                out_valid,
    output logic      [FEATURE_W-1:0]                features,
    output logic      [OUT_COUNT-1:0][FEATURE_W-1:0] weights,
    output logic      [OUT_COUNT-1:0][BYTE_W-1:0]    biases,
    output logic                                     start
);

    // Word counter wide enough for a whole frame
    localparam int CNT_W      = $clog2(FRAME_WORDS);
    // Layout of the frame in words
    localparam int FEAT_WORDS = FEATURE_W / WORD_W;
    localparam int BIAS_WORD  = FRAME_WORDS - 1;

    loader_state_t    state;
    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] widx;
    logic             accept;
    logic             last_word;

    // A word only counts while receiving
    assign accept    = in_valid && (state == LOAD_RECEIVE);
    assign last_word = (word_cnt == CNT_W'(BIAS_WORD));
    // Offset into the weight section
    assign widx      = word_cnt - CNT_W'(FEAT_WORDS);

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= LOAD_RECEIVE;
            word_cnt <= '0;
            start    <= 1'b0;
        end else begin
            // One-cycle pulse by default
            start <= 1'b0;
            case (state)
                LOAD_RECEIVE: begin
                    if (accept) begin
                        if (last_word) begin
                            word_cnt <= '0;
                            state    <= LOAD_COMPUTE;
                            start    <= 1'b1;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                LOAD_COMPUTE: begin
                    // Hold data for the lanes until the result leaves
                    if (out_valid) begin
                        state <= LOAD_RECEIVE;
                    end
                end
                default: state <= LOAD_RECEIVE;
            endcase
        end
    end

    //////////////////////////////
    // Frame registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            if (word_cnt < CNT_W'(FEAT_WORDS)) begin
                // Features k..k+3 in bytes 0..3
                features[word_cnt * WORD_W +: WORD_W] <= in_data;
            end else if (last_word) begin
                // Byte j is the bias of output j
                biases <= in_data;
            end else begin
                // Two words per output row, low half first
                weights[widx[2:1]][widx[0] * WORD_W +: WORD_W] <= in_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/fc_neuron_lane.sv
// FC neuron lane
`timescale 1ns/1ns
`default_nettype none

module fc_neuron_lane
    import fc_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 start,
    input  wire logic [FEATURE_W-1:0] features,
    input  wire logic [FEATURE_W-1:0] weights,
    input  wire logic [BYTE_W-1:0]    bias,
    output logic      [ACC_W-1:0]     sum,
    output logic                      done
);

    lane_state_t               state;
    logic [STEP_W-1:0]         step;
    logic [ACC_W-1:0]          acc;

    logic signed [BYTE_W-1:0]   feat_byte;
    logic signed [BYTE_W-1:0]   wgt_byte;
    logic signed [2*BYTE_W-1:0] product;
    logic        [ACC_W-1:0]    product_ext;
    logic        [ACC_W-1:0]    bias_ext;

    //////////////////////////////
    // Datapath
    //////////////////////////////

    // Byte at the current step position
    assign feat_byte = features[step * BYTE_W +: BYTE_W];
    assign wgt_byte  = weights[step * BYTE_W +: BYTE_W];
    assign product   = feat_byte * wgt_byte;

    // Sign extension up to the accumulator width
    assign product_ext = {{(ACC_W - 2 * BYTE_W){product[2*BYTE_W-1]}}, product};
    assign bias_ext    = {{(ACC_W - BYTE_W){bias[BYTE_W-1]}}, bias};

    // Accumulator, cleared on every start
    always_ff @(posedge clk) begin
        case (state)
            LANE_IDLE:       if (start) acc <= '0;
            LANE_ACCUMULATE: acc <= acc + product_ext;
            LANE_BIAS_ADD:   acc <= acc + bias_ext;
            default:         acc <= acc;
        endcase
    end

    //////////////////////////////
    // Step FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= LANE_IDLE;
            step  <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    step <= '0;
                    if (start) state <= LANE_ACCUMULATE;
                end
                LANE_ACCUMULATE: begin
                    // Eight steps, then the bias
                    if (step == STEP_W'(IN_COUNT - 1)) begin
                        state <= LANE_BIAS_ADD;
                    end
                    step <= step + 1'b1;
                end
                LANE_BIAS_ADD: state <= LANE_DONE;
                LANE_DONE:     state <= LANE_IDLE;
                default:       state <= LANE_IDLE;
            endcase
        end
    end

    // Full-width sum, quantized downstream
    assign sum  = acc;
    assign done = (state == LANE_DONE);

endmodule

`default_nettype wire

//--- src/fc_output_packer.sv
// FC output packer
`timescale 1ns/1ns
`default_nettype none

module fc_output_packer
    import fc_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rstn,
    input  wire logic [OUT_COUNT-1:0][ACC_W-1:0] sums,
    input  wire logic [OUT_COUNT-1:0]            lane_done,
    output logic                                 out_valid,
    output logic      [WORD_W-1:0]               out_data
);

    // Bits from the MSB down to Q_MSB must agree for an in-range sum
    // Result keeps the sign over sum bits Q_MSB-1..Q_LSB
    localparam int Q_LSB = BYTE_W;
    localparam int Q_MSB = Q_LSB + BYTE_W - 1;

    logic [OUT_COUNT-1:0][BYTE_W-1:0] packed_q;
    logic                             all_done;

    // Saturating int8 quantization of one sum
    function automatic logic [BYTE_W-1:0] quantize(input logic [ACC_W-1:0] s);
        logic [ACC_W-Q_MSB-1:0] top;
        top = s[ACC_W-1:Q_MSB];
        if ((top == '0) || (top == '1)) begin
            return {s[ACC_W-1], s[Q_MSB-1:Q_LSB]};
        end
        // Out of range, clip by sign
        return s[ACC_W-1] ? {1'b1, {(BYTE_W-1){1'b0}}} : {1'b0, {(BYTE_W-1){1'b1}}};
    endfunction

    // Output j lands in byte j
    always_comb begin
        for (int j = 0; j < OUT_COUNT; j++) begin
            packed_q[j] = quantize(sums[j]);
        end
    end

    assign all_done = &lane_done;

    //////////////////////////////
    // Result register
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= all_done;
            // Holds until the next frame
            if (all_done) out_data <= packed_q;
        end
    end

endmodule

`default_nettype wire

//--- src/fc_layer_top.sv
// FC layer top level
`timescale 1ns/1ns
`default_nettype none

module fc_layer_top
    import fc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              in_valid,
    input  wire logic [WORD_W-1:0] in_data,
    output logic                   out_valid,
    output logic      [WORD_W-1:0] out_data
);

    // Loader to lanes
    logic [FEATURE_W-1:0]                features;
    logic [OUT_COUNT-1:0][FEATURE_W-1:0] weights;
    logic [OUT_COUNT-1:0][BYTE_W-1:0]    biases;
    logic                                start;

    // Lanes to packer
    logic [OUT_COUNT-1:0][ACC_W-1:0]     sums;
    logic [OUT_COUNT-1:0]                lane_done;

    fc_frame_loader u_loader (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .features  (features),
        .weights   (weights),
        .biases    (biases),
        .start     (start)
    );

    //////////////////////////////
    // One lane per output
    //////////////////////////////

    for (genvar j = 0; j < OUT_COUNT; j++) begin : g_lane
        fc_neuron_lane u_lane (
            .clk      (clk),
            .rstn     (rstn),
            .start    (start),
            .features (features),
            .weights  (weights[j]),
            .bias     (biases[j]),
            .sum      (sums[j]),
            .done     (lane_done[j])
        );
    end

    fc_output_packer u_packer (
        .clk       (clk),
        .rstn      (rstn),
        .sums      (sums),
        .lane_done (lane_done),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- tb/fc_layer_chk.sv
// FC layer protocol checker
`timescale 1ns/1ns
`default_nettype none

module fc_layer_chk
    import fc_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 rstn,
    input wire logic                 start,
    input wire logic [OUT_COUNT-1:0] lane_done,
    input wire logic                 out_valid
);

    // Failed assertions, read by the testbench verdict
    int fail_count = 0;

    //////////////////////////////
    // Output pulse shape
    //////////////////////////////

    // out_valid is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid high on two consecutive cycles");
            fail_count++;
        end

    // Lanes run in lockstep
    a_lanes_equal: assert property (@(posedge clk) disable iff (!rstn)
        (lane_done == '0) || (lane_done == '1))
        else begin
            $error("lane done signals differ");
            fail_count++;
        end

    // Fixed latency from start to result
    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        start |-> ##11 out_valid)
        else begin
            $error("out_valid not 11 cycles after start");
            fail_count++;
        end

    // Quiet output while in reset
    a_reset_quiet: assert property (@(posedge clk) !rstn |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

endmodule

bind fc_layer_top fc_layer_chk u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .lane_done (lane_done),
    .out_valid (out_valid)
);

`default_nettype wire

//--- tb/tb_fc_layer.sv
// FC layer testbench
`timescale 1ns/1ns
`default_nettype none

module tb_fc_layer
    import fc_pkg::*;
;

    //////////////////////////////
    // Test constants
    //////////////////////////////

    localparam int  PERIOD       = 100;
    localparam int  RESET_CYCLES = 3;
    localparam int  IDLE_CYCLES  = 4;
    localparam int  LATENCY      = 11;
    localparam int  MAX_GAP      = 3;
    localparam int  MARGIN       = 8;
    localparam int  RAND_FRAMES  = 20;
    // Five directed frames plus the random ones
    localparam int  NUM_FRAMES   = 5 + RAND_FRAMES;
    localparam int  FRAME_BITS   = FRAME_WORDS * WORD_W;
    localparam logic [31:0] SEED = 32'h15b9b3e8;

    // Every frame sent with the largest gap after each word
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES
        + NUM_FRAMES * (FRAME_WORDS * (1 + MAX_GAP) + LATENCY + MARGIN);

    logic              clk;
    logic              rstn;
    logic              in_valid;
    logic [WORD_W-1:0] in_data;
    logic              out_valid;
    logic [WORD_W-1:0] out_data;

    logic [31:0]       rng_state;
    logic [WORD_W-1:0] expected_q[$];
    time               last_accept_time;
    int                frames_checked = 0;

    fc_layer_top uut (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected packed result of one frame
    function automatic logic [WORD_W-1:0] ref_layer(input logic [FRAME_BITS-1:0] frame);
        logic [WORD_W-1:0]        result;
        logic signed [BYTE_W-1:0] f;
        logic signed [BYTE_W-1:0] w;
        logic signed [BYTE_W-1:0] b;
        logic [19:0]              s;
        int                       acc;
        result = '0;
        for (int j = 0; j < OUT_COUNT; j++) begin
            acc = 0;
            for (int k = 0; k < IN_COUNT; k++) begin
                // Feature k sits in word k/4, byte k%4
                f = frame[(k / 4) * WORD_W + (k % 4) * BYTE_W +: BYTE_W];
                // Row j starts at word 2+2j
                w = frame[(2 + 2 * j + k / 4) * WORD_W + (k % 4) * BYTE_W +: BYTE_W];
                acc = acc + f * w;
            end
            b = frame[10 * WORD_W + j * BYTE_W +: BYTE_W];
            acc = acc + b;
            s = acc[19:0];
            if ((s[19:15] == 5'b00000) || (s[19:15] == 5'b11111)) begin
                result[j * BYTE_W +: BYTE_W] = {s[19], s[14:8]};
            end else if (acc < 0) begin
                result[j * BYTE_W +: BYTE_W] = 8'h80;
            end else begin
                result[j * BYTE_W +: BYTE_W] = 8'h7F;
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Drive one frame, random gaps of 0..max_gap cycles between words
    task automatic send_frame(input logic [FRAME_BITS-1:0] frame, input int max_gap);
        int gap;
        expected_q.push_back(ref_layer(frame));
        for (int i = 0; i < FRAME_WORDS; i++) begin
            in_valid = 1'b1;
            in_data  = frame[i * WORD_W +: WORD_W];
            @(posedge clk);
            // Edge that accepts the word
            if (i == FRAME_WORDS - 1) last_accept_time = $time;
            #1;
            in_valid = 1'b0;
            in_data  = '0;
            if ((i < FRAME_WORDS - 1) && (max_gap > 0)) begin
                rng_state = xorshift32(rng_state);
                gap = rng_state % (max_gap + 1);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        // Next frame starts on the cycle after out_valid
        do @(negedge clk); while (!out_valid);
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        logic [FRAME_BITS-1:0] frame;
        clk       = 1'b0;
        rstn      = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        rng_state = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
        // Idle cycles to watch the reset values
        repeat (IDLE_CYCLES) @(posedge clk);
        #1;
        // Small values, word 10 down to word 0
        send_frame({32'h05FB7F80, 32'h0A0A0A0A, 32'h0A0A0A0A, 32'h00000001, 32'h7F000000,
                    32'hE0F0F8FC, 32'h20101008, 32'h0806FA02, 32'h10F00C04,
                    32'h0C121820, 32'h1A140E08}, 0);
        // Positive saturation
        send_frame({32'h01020304, {8{32'h7F7F7F7F}}, {2{32'h7F7F7F7F}}}, 0);
        // Negative saturation
        send_frame({32'hFFFEFDFC, {8{32'h80808080}}, {2{32'h7F7F7F7F}}}, 0);
        // Sums of 32767, 32768, -32768 and -32769
        send_frame({32'hFF00403F, 32'h00000000, 32'h80808080, 32'h00000000, 32'h80808080,
                    32'h00000003, 32'h7F7F7F7F, 32'h00000003, 32'h7F7F7F7F,
                    32'h40404040, 32'h40404040}, 0);
        // Mixed signs
        send_frame({32'h80FF017F, 32'h81C03F7F, 32'h01FF01FF, 32'h7F7F8080, 32'h10F0E020,
                    32'hF00F7E81, 32'h40C080FF, 32'h02FE037D, 32'h7F80FF01,
                    32'h81017F80, 32'h05FB0AF6}, 0);
        // Random frames and gaps
        repeat (RAND_FRAMES) begin
            for (int i = 0; i < FRAME_WORDS; i++) begin
                rng_state = xorshift32(rng_state);
                frame[i * WORD_W +: WORD_W] = rng_state;
            end
            send_frame(frame, MAX_GAP);
        end
    end

    //////////////////////////////
    // Compare and verdict
    //////////////////////////////

    initial begin : compare
        logic [WORD_W-1:0] expected;
        wait (rstn === 1'b1);
        while (frames_checked < NUM_FRAMES) begin
            @(negedge clk);
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("out_valid came without a frame having been sent");
                    $display("** FAIL **");
                    $fatal(1, "Unexpected result");
                end
                expected = expected_q.pop_front();
                check_value("out_data", out_data, expected);
                // Eleven edges after the last word, seen half a period later
                check_value("out_valid latency", $time - last_accept_time,
                            LATENCY * PERIOD + PERIOD / 2);
                frames_checked++;
            end else if (frames_checked == 0) begin
                // Reset value holds until the first result
                check_value("out_data", out_data, '0);
            end
        end
        if (uut.u_chk.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Protocol checker saw %0d failed assertions", uut.u_chk.fail_count);
            $display("** FAIL **");
            $fatal(1, "Assertion failures");
        end
    end

    // Watchdog
    initial begin : watchdog
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Timeout: out_valid never came for frame %0d of %0d",
                 frames_checked + 1, NUM_FRAMES);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- compile.f
src/fc_pkg.sv
src/fc_frame_loader.sv
src/fc_neuron_lane.sv
src/fc_output_packer.sv
src/fc_layer_top.sv
tb/fc_layer_chk.sv
tb/tb_fc_layer.sv
